/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_exec
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "test passed" || \
		{ echo "test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module alu (
    input logic   clk,
    input logic   rst_n,
    exec_if.dst   in,
    mem_if.src    out
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [31:0]      aw;
    logic [31:0]      bw;
    logic [`XLEN-1:0] res;
    logic [31:0]      w_res;
    logic             is_word;
    logic             taken;

    assign a  = in.src1;
    assign b  = in.src2;
    assign aw = a[31:0];
    assign bw = b[31:0];

    assign is_word = in.alu_op inside {ALU_ADDW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
                                       ALU_DIVW, ALU_REMW};

    always_comb begin
        res   = '0;
        w_res = '0;
        taken = 1'b0;
        case (in.alu_op)
            ALU_ADD:  res = a + b; // also load/store address
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << b[5:0];
            ALU_SRL:  res = a >> b[5:0];
            ALU_SRA:  res = $signed(a) >>> b[5:0];
            ALU_SLT:  res = {63'd0, $signed(a) < $signed(b)};
            ALU_SLTU: res = {63'd0, a < b};
            ALU_MUL:  res = a * b;
            ALU_DIVU: begin
                if (b == '0) begin
                    res = '1;
                end else begin
                    res = a / b;
                end
            end
            ALU_REMU: begin
                if (b == '0) begin
                    res = a;
                end else begin
                    res = a % b;
                end
            end
            ALU_ADDW: w_res = aw + bw;
            ALU_SLLW: w_res = aw << b[4:0];
            ALU_SRLW: w_res = aw >> b[4:0];
            ALU_SRAW: w_res = $signed(aw) >>> b[4:0];
            ALU_DIVW: begin
                if (bw == '0) begin
                    w_res = '1;
                end else begin
                    w_res = $signed(aw) / $signed(bw); // overflow wraps to min
                end
            end
            ALU_REMW: begin
                if (bw == '0) begin
                    w_res = aw;
                end else begin
                    w_res = $signed(aw) % $signed(bw);
                end
            end
            ALU_BEQ:  taken = (a == b);
            ALU_BNE:  taken = (a != b);
            ALU_BLT:  taken = ($signed(a) < $signed(b));
            ALU_BGE:  taken = ($signed(a) >= $signed(b));
            ALU_BLTU: taken = (a < b);
            ALU_BGEU: taken = (a >= b);
            ALU_PASS: res = b;
            default:  res = '0;
        endcase
        if (is_word) begin
            res = {{32{w_res[31]}}, w_res};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out.mem_op     <= in.mem_op;
        out.rd         <= in.rd;
        out.wb_en      <= in.wb_en;
        out.is_branch  <= in.is_branch;
        out.br_taken   <= taken;
        out.result     <= res;
        out.store_data <= in.store_data;
    end

    // decode must never request a writeback for a compare
    branch_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        in.valid && in.is_branch |-> !in.wb_en);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [31:0]        instr,
    output logic [`REG_AW-1:0] rs1_addr,
    output logic [`REG_AW-1:0] rs2_addr,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    exec_if.src                out
);
    import rv_exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP32   = 7'b0111011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_IMM32  = 7'b0011011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    instr_u             iw;
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic [`REG_AW-1:0] rd_sel;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    alu_op_e            op;
    mem_op_e            mop;
    logic               legal;
    logic               wb;
    logic               br;
    logic               use_imm;
    logic               is_store;

    assign iw = instr;

    // rd, rs1 and funct3 sit at the same bits in both views
    assign f3       = iw.r.funct3;
    assign rd_sel   = iw.r.rd;
    assign rs1_addr = iw.r.rs1;
    assign rs2_addr = iw.r.rs2;
    assign f7       = iw.r.funct7;

    assign imm_i = {{52{iw.i.imm12[11]}}, iw.i.imm12};
    assign imm_s = {{52{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rd}; // s-type split field

    always_comb begin
        op       = ALU_PASS;
        mop      = MEM_NONE;
        legal    = 1'b0;
        wb       = 1'b0;
        br       = 1'b0;
        use_imm  = 1'b0;
        is_store = 1'b0;
        case (iw.r.opcode)
            OPC_OP: begin
                legal = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'b000}: op = ALU_ADD;
                    {7'h20, 3'b000}: op = ALU_SUB;
                    {7'h00, 3'b001}: op = ALU_SLL;
                    {7'h00, 3'b010}: op = ALU_SLT;
                    {7'h00, 3'b011}: op = ALU_SLTU;
                    {7'h00, 3'b100}: op = ALU_XOR;
                    {7'h00, 3'b101}: op = ALU_SRL;
                    {7'h20, 3'b101}: op = ALU_SRA;
                    {7'h00, 3'b110}: op = ALU_OR;
                    {7'h00, 3'b111}: op = ALU_AND;
                    {7'h01, 3'b000}: op = ALU_MUL;
                    {7'h01, 3'b101}: op = ALU_DIVU;
                    {7'h01, 3'b111}: op = ALU_REMU;
                    default:         legal = 1'b0;
                endcase
                wb = legal;
            end
            OPC_OP32: begin
                legal = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'b000}: op = ALU_ADDW;
                    {7'h00, 3'b001}: op = ALU_SLLW;
                    {7'h00, 3'b101}: op = ALU_SRLW;
                    {7'h20, 3'b101}: op = ALU_SRAW;
                    {7'h01, 3'b100}: op = ALU_DIVW;
                    {7'h01, 3'b110}: op = ALU_REMW;
                    default:         legal = 1'b0;
                endcase
                wb = legal;
            end
            OPC_IMM: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                case (f3)
                    3'b000: op = ALU_ADD;
                    3'b010: op = ALU_SLT;
                    3'b011: op = ALU_SLTU;
                    3'b100: op = ALU_XOR;
                    3'b110: op = ALU_OR;
                    3'b111: op = ALU_AND;
                    3'b001: op = ALU_SLL;
                    default: op = iw.i.imm12[10] ? ALU_SRA : ALU_SRL; // funct6 picks srai
                endcase
                wb = 1'b1;
            end
            OPC_IMM32: begin
                legal   = (f3 == 3'b000); // addiw only
                use_imm = 1'b1;
                op      = ALU_ADDW;
                wb      = legal;
            end
            OPC_LOAD: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                op      = ALU_ADD;
                case (f3)
                    3'b011:  mop = MEM_LD;
                    3'b010:  mop = MEM_LW;
                    3'b001:  mop = MEM_LH;
                    3'b000:  mop = MEM_LB;
                    default: legal = 1'b0;
                endcase
                wb = legal;
            end
            OPC_STORE: begin
                legal    = 1'b1;
                is_store = 1'b1;
                op       = ALU_ADD;
                case (f3)
                    3'b011:  mop = MEM_SD;
                    3'b010:  mop = MEM_SW;
                    3'b000:  mop = MEM_SB;
                    default: legal = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                legal = 1'b1;
                br    = 1'b1;
                case (f3)
                    3'b000:  op = ALU_BEQ;
                    3'b001:  op = ALU_BNE;
                    3'b100:  op = ALU_BLT;
                    3'b101:  op = ALU_BGE;
                    3'b110:  op = ALU_BLTU;
                    3'b111:  op = ALU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0; // bubble
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        out.alu_op     <= op;
        out.mem_op     <= mop;
        out.rd         <= rd_sel;
        out.wb_en      <= wb;
        out.is_branch  <= br;
        out.src1       <= rs1_data;
        out.src2       <= is_store ? imm_s : (use_imm ? imm_i : rs2_data);
        out.store_data <= rs2_data;
    end

endmodule

/* exec_checker.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module exec_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [31:0]        instr,
    input  logic               wb_valid,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    input  logic               br_valid,
    input  logic               br_taken,
    output int                 error_count,
    output int                 missing_count
);

    localparam int ISSUE_TO_RESULT = 3; // cycles from issue edge to result sample

    logic [31:0]        file_instr [$];
    int                 file_kind [$];
    logic [`REG_AW-1:0] file_rd [$];
    logic [`XLEN-1:0]   file_data [$];

    // issued instructions whose result is still due
    int                 exp_kind [$];
    logic [`REG_AW-1:0] exp_rd [$];
    logic [`XLEN-1:0]   exp_data [$];
    int                 exp_cycle [$];

    int cycle;
    int errors;
    int open_errors;
    int seen;
    int expected_total;

    assign error_count   = errors + open_errors;
    assign missing_count = expected_total - seen;

    initial begin : load_file
        int                 fd;
        int                 idle;
        int                 kind;
        logic [31:0]        w;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   d;
        logic [8*160-1:0]   line;
        fd = $fopen("exec_input.txt", "r");
        if (fd == 0) begin
            $display("checker could not open exec_input.txt");
            open_errors = 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %d %d %d %h", w, idle, kind, rd, d) == 5) begin
                    file_instr.push_back(w);
                    file_kind.push_back(kind);
                    file_rd.push_back(rd);
                    file_data.push_back(d);
                    if (kind != 0) begin
                        expected_total = expected_total + 1;
                    end
                end
            end
            $fclose(fd);
        end
    end

    task automatic record_issue();
        if (file_instr.size() == 0) begin
            $display("instruction %h issued with no entry left in exec_input.txt", instr);
            errors = errors + 1;
        end else begin
            if (file_instr[0] !== instr) begin
                $display("issued instruction %h does not match file entry %h",
                         instr, file_instr[0]);
                errors = errors + 1;
            end
            if (file_kind[0] != 0) begin
                exp_kind.push_back(file_kind[0]);
                exp_rd.push_back(file_rd[0]);
                exp_data.push_back(file_data[0]);
                exp_cycle.push_back(cycle);
            end
            void'(file_instr.pop_front());
            void'(file_kind.pop_front());
            void'(file_rd.pop_front());
            void'(file_data.pop_front());
        end
    endtask

    task automatic check_result();
        int                 kind;
        int                 lat;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   d;
        if (exp_kind.size() == 0) begin
            $display("result in cycle %0d with no expected entry left", cycle);
            errors = errors + 1;
        end else begin
            kind = exp_kind.pop_front();
            rd   = exp_rd.pop_front();
            d    = exp_data.pop_front();
            lat  = cycle - exp_cycle.pop_front();
            seen = seen + 1;
            if (kind == 1 && !wb_valid) begin
                $display("expected a writeback to x%0d, got a branch result", rd);
                errors = errors + 1;
            end else if (kind == 2 && !br_valid) begin
                $display("expected a branch result, got a writeback to x%0d", wb_rd);
                errors = errors + 1;
            end else if (kind == 1) begin
                if (wb_rd !== rd) begin
                    $display("FAIL wb_rd: expected %h, got %h", rd, wb_rd);
                    errors = errors + 1;
                end
                if (wb_data !== d) begin
                    $display("FAIL wb_data: expected %h, got %h", d, wb_data);
                    errors = errors + 1;
                end
            end else if (br_taken !== d[0]) begin
                $display("FAIL br_taken: expected %h, got %h", d[0], br_taken);
                errors = errors + 1;
            end
            if (lat != ISSUE_TO_RESULT) begin
                $display("result came %0d cycles after issue instead of %0d",
                         lat, ISSUE_TO_RESULT);
                errors = errors + 1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (in_valid) begin
                record_issue();
            end
            if (wb_valid && br_valid) begin
                $display("writeback and branch result in the same cycle %0d", cycle);
                errors = errors + 1;
            end else if (wb_valid || br_valid) begin
                check_result();
            end
        end
    end

endmodule

/* exec_input.txt */
// columns: instr(hex) idle_cycles kind(0 none, 1 writeback, 2 branch) rd data_or_taken(hex)
// dependent instructions sit at least two issue slots after their producer
00a00093 2 1  1 000000000000000a // addi x1, x0, 10
ffd00113 2 1  2 fffffffffffffffd // addi x2, x0, -3
7ff08193 2 1  3 0000000000000809 // addi x3, x1, 2047
00208233 2 1  4 0000000000000007 // add x4, x1, x2
402082b3 2 1  5 000000000000000d // sub x5, x1, x2
00117333 2 1  6 0000000000000008 // and x6, x2, x1
001163b3 2 1  7 ffffffffffffffff // or x7, x2, x1
00114433 2 1  8 fffffffffffffff7 // xor x8, x2, x1
001124b3 2 1  9 0000000000000001 // slt x9, x2, x1
00113533 2 1 10 0000000000000000 // sltu x10, x2, x1
00108033 2 0  0 0000000000000000 // add x0, x1, x1 (no writeback)
ffe12593 2 1 11 0000000000000001 // slti x11, x2, -2
fff0b613 2 1 12 0000000000000001 // sltiu x12, x1, -1
fff0c693 2 1 13 fffffffffffffff5 // xori x13, x1, -1
0f017713 2 1 14 00000000000000f0 // andi x14, x2, 0xf0
1000e793 2 1 15 000000000000010a // ori x15, x1, 0x100
03c09813 2 1 16 a000000000000000 // slli x16, x1, 60
43e85893 2 1 17 fffffffffffffffe // srai x17, x16, 62
03d85913 2 1 18 0000000000000005 // srli x18, x16, 61
002099b3 2 1 19 4000000000000000 // sll x19, x1, x2 (amount 61)
00215a33 2 1 20 0000000000000007 // srl x20, x2, x2
40115ab3 2 1 21 ffffffffffffffff // sra x21, x2, x1
01109bbb 2 1 23 ffffffff80000000 // sllw x23, x1, x17 (amount 30)
017b8b3b 2 1 22 0000000000000000 // addw x22, x23, x23
001bdc3b 2 1 24 0000000000200000 // srlw x24, x23, x1
401bdcbb 2 1 25 ffffffffffe00000 // sraw x25, x23, x1
fffb8d1b 2 1 26 000000007fffffff // addiw x26, x23, -1
02310db3 2 1 27 ffffffffffffe7e5 // mul x27, x2, x3
0211de33 2 1 28 00000000000000cd // divu x28, x3, x1
0211feb3 2 1 29 0000000000000007 // remu x29, x3, x1
0201df33 2 1 30 ffffffffffffffff // divu x30, x3, x0
0201ffb3 2 1 31 0000000000000809 // remu x31, x3, x0
022bcdbb 2 1 27 000000002aaaaaaa // divw x27, x23, x2
022bee3b 2 1 28 fffffffffffffffe // remw x28, x23, x2
0200cebb 2 1 29 ffffffffffffffff // divw x29, x1, x0
020bef3b 2 1 30 ffffffff80000000 // remw x30, x23, x0
00873023 2 0  0 0000000000000000 // sd x8, 0(x14)
00172223 2 0  0 0000000000000000 // sw x1, 4(x14)
00170123 2 0  0 0000000000000000 // sb x1, 2(x14)
00073803 2 1 16 0000000aff0afff7 // ld x16, 0(x14)
00072883 2 1 17 ffffffffff0afff7 // lw x17, 0(x14)
00472903 2 1 18 000000000000000a // lw x18, 4(x14)
00271983 2 1 19 ffffffffffffff0a // lh x19, 2(x14)
00471c03 2 1 24 000000000000000a // lh x24, 4(x14)
00270a03 2 1 20 000000000000000a // lb x20, 2(x14)
00070a83 2 1 21 fffffffffffffff7 // lb x21, 0(x14)
00108063 0 2  0 0000000000000001 // beq x1, x1
00109063 0 2  0 0000000000000000 // bne x1, x1
00114063 0 2  0 0000000000000001 // blt x2, x1
00115063 0 2  0 0000000000000000 // bge x2, x1
00116063 0 2  0 0000000000000000 // bltu x2, x1
00117063 0 2  0 0000000000000001 // bgeu x2, x1
0020e063 0 2  0 0000000000000001 // bltu x1, x2
0020d063 0 2  0 0000000000000001 // bge x1, x2
00100293 0 1  5 0000000000000001 // addi x5, x0, 1
00200313 0 1  6 0000000000000002 // addi x6, x0, 2
0000006f 0 0  0 0000000000000000 // jal, unsupported, bubble
fff08493 0 1  9 0000000000000009 // addi x9, x1, -1
00108533 0 1 10 0000000000000014 // add x10, x1, x1
401005b3 0 1 11 fffffffffffffff6 // sub x11, x0, x1

/* filelist.f */
+incdir+.
rv_exec_pkg.sv
pipe_ifs.sv
decode_stage.sv
reg_file.sv
alu.sv
mem_stage.sv
rv_exec_top.sv
exec_checker.sv
tb_rv_exec.sv

/* mem_stage.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    mem_if.dst                 in,
    output logic               wr_en,
    output logic [`REG_AW-1:0] wr_addr,
    output logic [`XLEN-1:0]   wr_data,
    output logic               wb_valid,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data,
    output logic               br_valid,
    output logic               br_taken
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0]    dmem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] widx;
    logic [2:0]          boff;
    logic [`XLEN-1:0]    rd_shift;
    logic [`XLEN-1:0]    ld_data;
    logic [`XLEN-1:0]    st_data;
    logic [7:0]          be;
    logic [2:0]          align_mask;
    logic                is_load;

    assign widx     = in.result[`DMEM_AW+2:3];
    assign boff     = in.result[2:0];
    assign rd_shift = dmem[widx] >> {boff, 3'b000}; // selected lane to bit 0
    assign st_data  = in.store_data << {boff, 3'b000};
    assign is_load  = in.mem_op inside {MEM_LD, MEM_LW, MEM_LH, MEM_LB};

    always_comb begin
        ld_data    = rd_shift;
        be         = 8'h00;
        align_mask = 3'b000;
        case (in.mem_op)
            MEM_LW: ld_data = {{32{rd_shift[31]}}, rd_shift[31:0]};
            MEM_LH: ld_data = {{48{rd_shift[15]}}, rd_shift[15:0]};
            MEM_LB: ld_data = {{56{rd_shift[7]}}, rd_shift[7:0]};
            MEM_SD: be = 8'hff;
            MEM_SW: be = 8'h0f << boff;
            MEM_SB: be = 8'h01 << boff;
            default: ;
        endcase
        case (in.mem_op)
            MEM_LD, MEM_SD: align_mask = 3'b111;
            MEM_LW, MEM_SW: align_mask = 3'b011;
            MEM_LH:         align_mask = 3'b001;
            default:        align_mask = 3'b000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (in.valid) begin
            for (int j = 0; j < 8; j++) begin
                if (be[j]) begin
                    dmem[widx][j*8 +: 8] <= st_data[j*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            wb_valid <= in.valid && in.wb_en && (in.rd != '0);
            br_valid <= in.valid && in.is_branch;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= in.rd;
        wb_data  <= is_load ? ld_data : in.result;
        br_taken <= in.br_taken;
    end

    assign wr_en   = wb_valid;
    assign wr_addr = wb_rd;
    assign wr_data = wb_data;

    // accesses aligned to their size
    mem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        in.valid && in.mem_op != MEM_NONE |-> (boff & align_mask) == 3'b000);

endmodule

/* pipe_ifs.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

interface exec_if;
    import rv_exec_pkg::*;

    logic               valid;
    alu_op_e            alu_op;
    mem_op_e            mem_op;
    logic [`REG_AW-1:0] rd;
    logic               wb_en;
    logic               is_branch;
    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;       // register or immediate
    logic [`XLEN-1:0]   store_data;

    modport src (output valid, alu_op, mem_op, rd, wb_en, is_branch, src1, src2, store_data);
    modport dst (input valid, alu_op, mem_op, rd, wb_en, is_branch, src1, src2, store_data);
endinterface

interface mem_if;
    import rv_exec_pkg::*;

    logic               valid;
    mem_op_e            mem_op;
    logic [`REG_AW-1:0] rd;
    logic               wb_en;
    logic               is_branch;
    logic               br_taken;
    logic [`XLEN-1:0]   result;     // address for memory ops
    logic [`XLEN-1:0]   store_data;

    modport src (output valid, mem_op, rd, wb_en, is_branch, br_taken, result, store_data);
    modport dst (input valid, mem_op, rd, wb_en, is_branch, br_taken, result, store_data);
endinterface

/* reg_file.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  logic               wr_en,
    input  logic [`REG_AW-1:0] wr_addr,
    input  logic [`XLEN-1:0]   wr_data
);

    logic [`XLEN-1:0] regs [`NREGS];
    logic             wr_live;

    assign wr_live = wr_en && (wr_addr != '0); // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle bypass of the write port
    assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

/* rv_exec_params.svh */
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// datapath width
`define XLEN 64

// architectural registers
`define NREGS 32
`define REG_AW 5

// byte-addressed data ram of 64-bit words
`define DMEM_WORDS 256
`define DMEM_AW 8

`endif

/* rv_exec_pkg.sv */
package rv_exec_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // one instruction word in register or immediate layout
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_MUL, ALU_DIVU, ALU_REMU,
        ALU_ADDW, ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_DIVW, ALU_REMW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_PASS // forwards src2
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LD,
        MEM_LW,
        MEM_LH,
        MEM_LB,
        MEM_SD,
        MEM_SW,
        MEM_SB
    } mem_op_e;

endpackage

/* rv_exec_top.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_exec_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [31:0]        instr,
    output logic               wb_valid,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data,
    output logic               br_valid,
    output logic               br_taken
);

    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic               wr_en;
    logic [`REG_AW-1:0] wr_addr;
    logic [`XLEN-1:0]   wr_data;

    exec_if ex_bus ();
    mem_if  mem_bus ();

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .out      (ex_bus.src)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (ex_bus.dst),
        .out   (mem_bus.src)
    );

    mem_stage u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (mem_bus.dst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .br_valid (br_valid),
        .br_taken (br_taken)
    );

endmodule

/* tb_rv_exec.sv */
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module tb_rv_exec;

    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_TIMEOUT = 200; // cycles

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic [31:0]        instr;
    logic               wb_valid;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;
    logic               br_valid;
    logic               br_taken;
    int                 error_count;
    int                 missing_count;

    rv_exec_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .br_valid (br_valid),
        .br_taken (br_taken)
    );

    exec_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .error_count   (error_count),
        .missing_count (missing_count)
    );

    always #10 clk = ~clk; // 20 ns period

    // one valid slot, then idle slots
    task automatic issue(input logic [31:0] word, input int idle);
        @(negedge clk);
        in_valid = 1'b1;
        instr    = word;
        repeat (idle) begin
            @(negedge clk);
            in_valid = 1'b0;
            instr    = '0;
        end
    endtask

    task automatic wait_drain(output bit timed_out);
        int waited;
        waited    = 0;
        timed_out = 1'b0;
        while (missing_count != 0 && !timed_out) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited >= DRAIN_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin : run
        int                 fd;
        int                 idle;
        int                 kind;
        logic [31:0]        w;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   d;
        logic [8*160-1:0]   line;
        bit                 timed_out;
        bit                 open_failed;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instr       = '0;
        timed_out   = 1'b0;
        open_failed = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("exec_input.txt", "r");
        if (fd == 0) begin
            $display("testbench could not open exec_input.txt");
            open_failed = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %d %d %d %h", w, idle, kind, rd, d) == 5) begin
                    issue(w, idle);
                end
            end
            $fclose(fd);
            @(negedge clk);
            in_valid = 1'b0;
            instr    = '0;
            wait_drain(timed_out);
            if (timed_out) begin
                $display("timeout after %0d cycles, %0d expected results never appeared",
                         DRAIN_TIMEOUT, missing_count);
            end
        end

        $display("errors: %0d, missing results: %0d", error_count, missing_count);
        if (error_count == 0 && missing_count == 0 && !timed_out && !open_failed) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
